//--- bench/lcd_tb.sv
module lcd_tb;
	import lcd_pkg::*;

	logic clk_reg;
	logic reset;
	logic wb_cyc;
	logic wb_stb;
	logic wb_we;
	logic [8:0] wb_adr;
	logic [7:0] wb_dat_w;
	logic [7:0] wb_dat_r;
	logic wb_ack;
	lcd_mode_t mode;
	logic lcd_on;
	logic irq;
	logic vblank_irq;
	logic dma_rd;
	logic [15:0] dma_addr;
	logic [7:0] dma_data = 8'h00;

	int errors = 0;
	integer seed;
	int r;
	int n;
	int i;
	int dma_high = 0;
	int dma_base;
	logic [7:0] rd;
	logic [7:0] oam_exp [oam_size];
	// {offset, write value, expected read, check only}
	logic [24:0] reg_table [10];
	logic [24:0] entry;

	lcd_top dut_i (.*);

	initial begin
		clk_reg = 1'b0;
		forever #4 clk_reg = ~clk_reg;
	end

	// dma source model answers one cycle after the address
	function automatic logic [7:0] dma_model(input logic [15:0] addr);
		return addr[15:8] ^ addr[7:0] ^ 8'h5a;
	endfunction

	always @(posedge clk_reg) dma_data <= dma_model(dma_addr);

	// cycles with dma_rd high sampled mid cycle
	always @(negedge clk_reg) if (dma_rd) dma_high <= dma_high + 1;

	// ------------------------------------------------------------------
	// checking and reporting
	// ------------------------------------------------------------------

	task automatic check_value(input string name, input int exp_val, input int got_val);
		assert (got_val == exp_val) else begin
			$display("FAIL %0t %s expected 'h%0h got 'h%0h", $time, name, exp_val, got_val);
			errors++;
		end
	endtask

	task automatic note_timeout(input string what);
		$display("ERROR at %0t: timed out waiting for %s", $time, what);
		errors++;
	endtask

	// ------------------------------------------------------------------
	// wishbone master
	// ------------------------------------------------------------------

	task automatic wb_cycle(input logic we, input logic [8:0] adr, input logic [7:0] wdata,
		output logic [7:0] rdata);
		int t;
		@(posedge clk_reg);
		wb_cyc <= 1'b1;
		wb_stb <= 1'b1;
		wb_we <= we;
		wb_adr <= adr;
		wb_dat_w <= wdata;
		t = 0;
		rdata = 8'h00;
		@(negedge clk_reg);
		while (!wb_ack && t < 4) begin
			@(negedge clk_reg);
			t++;
		end
		if (wb_ack)
			rdata = wb_dat_r;
		else
			note_timeout("wb_ack");
		// drop the request on the edge that ends ack
		@(posedge clk_reg);
		wb_cyc <= 1'b0;
		wb_stb <= 1'b0;
		wb_we <= 1'b0;
	endtask

	task automatic wb_write(input logic [8:0] adr, input logic [7:0] wdata);
		logic [7:0] dummy;
		wb_cycle(1'b1, adr, wdata, dummy);
	endtask

	task automatic wb_read(input logic [8:0] adr, output logic [7:0] rdata);
		wb_cycle(1'b0, adr, 8'h00, rdata);
	endtask

	// ------------------------------------------------------------------
	// mode and pulse watchers
	// ------------------------------------------------------------------

	task automatic wait_mode(input lcd_mode_t m, input int limit, input string what);
		int t;
		t = 0;
		@(negedge clk_reg);
		while (mode != m && t < limit) begin
			@(negedge clk_reg);
			t++;
		end
		if (mode != m)
			note_timeout(what);
	endtask

	// counts mid cycle samples while mode stays at m
	task automatic run_length(input lcd_mode_t m, input int limit, output int len);
		len = 0;
		while (mode == m && len < limit) begin
			len++;
			@(negedge clk_reg);
		end
	endtask

	task automatic wait_pulse(input bit vbl, input int limit, output int len);
		len = 1;
		@(negedge clk_reg);
		while (!(vbl ? vblank_irq : irq) && len < limit) begin
			@(negedge clk_reg);
			len++;
		end
		if (vbl && !vblank_irq)
			note_timeout("vblank_irq pulse");
		else if (!vbl && !irq)
			note_timeout("stat irq pulse");
	endtask

	// stat irq pulses from one vblank_irq to the next
	task automatic count_frame_irqs(output int cnt);
		int t;
		wait_pulse(1'b1, 71000, t);
		cnt = 0;
		t = 0;
		@(negedge clk_reg);
		while (!vblank_irq && t < 71000) begin
			if (irq)
				cnt++;
			@(negedge clk_reg);
			t++;
		end
		if (!vblank_irq)
			note_timeout("end of frame");
	endtask

	task automatic measure_line(input int exp_oam, input int exp_draw, input int exp_hbl);
		int len;
		wait_mode(mode_hblank, 500, "hblank");
		wait_mode(mode_oam, 5000, "start of line");
		run_length(mode_oam, 500, len);
		check_value("mode 2 length", exp_oam, len);
		run_length(mode_draw, 500, len);
		check_value("mode 3 length", exp_draw, len);
		run_length(mode_hblank, 500, len);
		check_value("mode 0 length", exp_hbl, len);
	endtask

	task automatic load_table();
		reg_table[0] = {reg_bgp, 8'h00, 8'hfc, 1'b1};
		reg_table[1] = {reg_lcdc, 8'h13, 8'h13, 1'b0};
		reg_table[2] = {reg_scy, 8'h5a, 8'h5a, 1'b0};
		reg_table[3] = {reg_scx, 8'ha7, 8'ha7, 1'b0};
		reg_table[4] = {reg_lyc, 8'h3c, 8'h3c, 1'b0};
		reg_table[5] = {reg_lyc, 8'h00, 8'h00, 1'b0};
		reg_table[6] = {reg_bgp, 8'he4, 8'he4, 1'b0};
		// top bit, all enables, coincidence, mode 0
		reg_table[7] = {reg_stat, 8'h78, 8'hfc, 1'b0};
		reg_table[8] = {reg_ly, 8'h00, 8'h00, 1'b1};
		reg_table[9] = {8'h4b, 8'h12, 8'hff, 1'b0};
	endtask

	// ------------------------------------------------------------------
	// main sequence
	// ------------------------------------------------------------------

	initial begin
		reset = 1'b1;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
		wb_adr = 9'h000;
		wb_dat_w = 8'h00;
		seed = 32'h9f3fb584;
		load_table();
		repeat (16) @(posedge clk_reg);
		reset <= 1'b0;

		// register table with the lcd off
		for (i = 0; i < 10; i++) begin
			entry = reg_table[i];
			if (!entry[0])
				wb_write({1'b0, entry[24:17]}, entry[16:9]);
			wb_read({1'b0, entry[24:17]}, rd);
			check_value($sformatf("wb_dat_r reg %02h", entry[24:17]), entry[8:1], rd);
		end
		// lcdc bit 7 is still clear
		@(negedge clk_reg);
		check_value("lcd_on", 0, lcd_on);

		// oam fill and read back with the lcd off
		for (i = 0; i < oam_size; i++) begin
			r = $random(seed);
			oam_exp[i] = r[7:0];
			wb_write({1'b1, 8'(i)}, oam_exp[i]);
		end
		for (i = 0; i < oam_size; i++) begin
			wb_read({1'b1, 8'(i)}, rd);
			check_value($sformatf("wb_dat_r oam %0d", i), oam_exp[i], rd);
		end
		wb_read({1'b1, 8'd160}, rd);
		check_value("wb_dat_r oam 160", 8'hff, rd);

		// dma from page c1
		dma_base = dma_high;
		wb_write({1'b0, reg_dma}, 8'hc1);
		n = 0;
		@(negedge clk_reg);
		while (dma_rd && n < 700) begin
			@(negedge clk_reg);
			n++;
		end
		if (dma_rd)
			note_timeout("dma_rd to fall");
		check_value("dma_rd high cycles", 640, dma_high - dma_base);
		for (i = 0; i < oam_size; i++) begin
			wb_read({1'b1, 8'(i)}, rd);
			check_value($sformatf("wb_dat_r dma %0d", i), dma_model({8'hc1, 8'(i)}), rd);
		end

		// line timing with the display on
		wb_write({1'b0, reg_scx}, 8'h00);
		wb_write({1'b0, reg_lcdc}, 8'h91);
		@(negedge clk_reg);
		check_value("lcd_on", 1, lcd_on);
		measure_line(80, 176, 200);
		wb_write({1'b0, reg_scx}, 8'h03);
		measure_line(80, 184, 192);
		// ppu owns oam in modes 2 and 3
		wait_mode(mode_oam, 500, "mode 2");
		wb_read({1'b1, 8'd0}, rd);
		check_value("wb_dat_r oam in mode 2", 8'hff, rd);
		wait_mode(mode_draw, 500, "mode 3");
		wb_read({1'b1, 8'd0}, rd);
		check_value("wb_dat_r oam in mode 3", 8'hff, rd);
		wait_mode(mode_vblank, 71000, "vblank");
		run_length(mode_vblank, 5000, n);
		check_value("vblank length", 10 * line_cycles, n);

		// interrupts
		wait_pulse(1'b1, 71000, n);
		wait_pulse(1'b1, 71000, n);
		check_value("vblank_irq spacing", 70224, n);
		wb_write({1'b0, reg_stat}, 8'h40);
		wb_write({1'b0, reg_lyc}, 8'h05);
		count_frame_irqs(n);
		check_value("irq per frame, lyc", 1, n);
		wait_pulse(1'b0, 71000, n);
		wb_read({1'b0, reg_ly}, rd);
		check_value("wb_dat_r ly after lyc irq", 8'h05, rd);
		wb_write({1'b0, reg_stat}, 8'h20);
		count_frame_irqs(n);
		check_value("irq per frame, mode 2", 154, n);

		errors += dut_i.assertions_i.fail_count;
		$display("errors: %0d", errors);
		if (errors == 0)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

//--- bench/lcd_tb_assertions.sv
module lcd_tb_assertions (
	input logic clk_reg,
	input logic reset,
	input logic wb_cyc,
	input logic wb_stb,
	input logic wb_ack,
	input lcd_pkg::lcd_mode_t mode,
	input logic lcd_on,
	input logic irq,
	input logic vblank_irq
);
	import lcd_pkg::*;

	// number of failed assertions
	int fail_count = 0;

	// ack answers a request sampled on the previous edge
	ack_after_req: assert property (@(posedge clk_reg) disable iff (reset)
		$rose(wb_ack) |-> $past(wb_cyc && wb_stb))
		else begin
			$error("wb_ack rose without cyc and stb sampled high");
			fail_count++;
		end

	// one ack per request
	ack_single: assert property (@(posedge clk_reg) disable iff (reset)
		wb_ack |=> !wb_ack)
		else begin
			$error("wb_ack high for two cycles in a row");
			fail_count++;
		end

	// display off parks the mode in hblank
	mode_off: assert property (@(posedge clk_reg) disable iff (reset)
		!lcd_on |-> (mode == mode_hblank))
		else begin
			$error("mode is not hblank while lcd_on is low");
			fail_count++;
		end

	irq_pulse: assert property (@(posedge clk_reg) disable iff (reset)
		irq |=> !irq)
		else begin
			$error("irq high for two consecutive cycles");
			fail_count++;
		end

	vblank_pulse: assert property (@(posedge clk_reg) disable iff (reset)
		vblank_irq |=> !vblank_irq)
		else begin
			$error("vblank_irq high for two consecutive cycles");
			fail_count++;
		end

endmodule

bind lcd_top lcd_tb_assertions assertions_i (
	.clk_reg (clk_reg),
	.reset (reset),
	.wb_cyc (wb_cyc),
	.wb_stb (wb_stb),
	.wb_ack (wb_ack),
	.mode (mode),
	.lcd_on (lcd_on),
	.irq (irq),
	.vblank_irq (vblank_irq)
);

//--- sources.f
src/lcd_pkg.sv
src/lcd_ifs.sv
src/lcd_timing.sv
src/lcd_regs.sv
src/oam_dma.sv
src/stat_irq.sv
src/lcd_top.sv
bench/lcd_tb_assertions.sv
bench/lcd_tb.sv

//--- src/lcd_ifs.sv
// position and mode from the timing generator, control back from the registers
interface lcd_timing_if;
	import lcd_pkg::*;

	h_cnt_t h_cnt;
	v_cnt_t v_cnt;
	lcd_mode_t mode;
	logic lcd_on;
	// scx[2:0] nonzero
	logic fine_scroll;

	modport timing (output h_cnt, output v_cnt, output mode, input lcd_on, input fine_scroll);
	modport regs (input h_cnt, input v_cnt, input mode, output lcd_on, output fine_scroll);
	modport observer (input h_cnt, input v_cnt, input mode, input lcd_on);
endinterface

// cpu side oam access and dma kick from the register block
interface oam_port_if;
	logic cpu_req;
	logic cpu_we;
	logic [7:0] cpu_index;
	logic [7:0] cpu_wdata;
	logic [7:0] cpu_rdata;
	logic dma_start;
	logic [7:0] dma_page;

	modport cpu (output cpu_req, cpu_we, cpu_index, cpu_wdata, dma_start, dma_page,
		input cpu_rdata);
	modport mem (input cpu_req, cpu_we, cpu_index, cpu_wdata, dma_start, dma_page,
		output cpu_rdata);
endinterface

//--- src/lcd_pkg.sv
package lcd_pkg;

	// ------------------------------------------------------------------
	// line and frame timing, all in clk_reg cycles
	// ------------------------------------------------------------------

	// clocks per line
	localparam int unsigned line_cycles = 456;
	// lines per frame, vblank included
	localparam int unsigned frame_lines = 154;
	// first vblank line
	localparam int unsigned visible_lines = 144;
	// mode 2 length
	localparam int unsigned oam_cycles = 80;
	// mode 3 length, no fine scroll
	localparam int unsigned mode3_base = 176;
	// one more tile fetch when scx is not 8 pixel aligned
	localparam int unsigned mode3_extra = 8;

	// ------------------------------------------------------------------
	// oam and dma
	// ------------------------------------------------------------------

	// 40 sprites of 4 bytes
	localparam int unsigned oam_size = 160;
	// clocks per dma byte
	localparam int unsigned dma_step = 4;

	// register offsets in the ff40 page
	localparam logic [7:0] reg_lcdc = 8'h40;
	localparam logic [7:0] reg_stat = 8'h41;
	localparam logic [7:0] reg_scy  = 8'h42;
	localparam logic [7:0] reg_scx  = 8'h43;
	localparam logic [7:0] reg_ly   = 8'h44;
	localparam logic [7:0] reg_lyc  = 8'h45;
	localparam logic [7:0] reg_dma  = 8'h46;
	localparam logic [7:0] reg_bgp  = 8'h47;

	// bgp after reset
	localparam logic [7:0] bgp_reset = 8'hfc;

	// stat mode field encoding
	typedef enum logic [1:0] {
		mode_hblank = 2'd0,
		mode_vblank = 2'd1,
		mode_oam    = 2'd2,
		mode_draw   = 2'd3
	} lcd_mode_t;

	// horizontal position 0..455, vertical 0..153
	typedef logic [8:0] h_cnt_t;
	typedef logic [7:0] v_cnt_t;

endpackage

//--- src/lcd_regs.sv
module lcd_regs (
	input  logic clk_reg,
	input  logic reset,
	input  logic wb_cyc,
	input  logic wb_stb,
	input  logic wb_we,
	input  logic [8:0] wb_adr,
	input  logic [7:0] wb_dat_w,
	output logic [7:0] wb_dat_r,
	output logic wb_ack,
	lcd_timing_if.regs tm,
	oam_port_if.cpu op,
	output logic [3:0] stat_en,
	output lcd_pkg::v_cnt_t lyc
);
	import lcd_pkg::*;

	// new request, sampled on the edge that raises ack
	logic req;
	logic reg_wr;
	logic lyc_match;
	logic [7:0] lcdc;
	logic [7:0] scy;
	logic [7:0] scx;
	logic [7:0] dma_page;
	logic [7:0] bgp;
	logic [7:0] reg_rdata;

	assign req = wb_cyc && wb_stb && !wb_ack;
	// address bit 8 clear selects the register page
	assign reg_wr = req && wb_we && !wb_adr[8];
	assign lyc_match = (tm.v_cnt == lyc);

	// ------------------------------------------------------------------
	// wishbone ack, one cycle per request
	// ------------------------------------------------------------------

	always_ff @(posedge clk_reg) begin
		if (reset)
			wb_ack <= 1'b0;
		else
			wb_ack <= req;
	end

	// read data held until the next request
	always_ff @(posedge clk_reg) begin
		if (req) begin
			if (wb_adr[8])
				wb_dat_r <= op.cpu_rdata;
			else
				wb_dat_r <= reg_rdata;
		end
	end

	// ------------------------------------------------------------------
	// register file
	// ------------------------------------------------------------------

	always_ff @(posedge clk_reg) begin
		if (reset) begin
			lcdc <= 8'h00;
			stat_en <= 4'h0;
			scy <= 8'h00;
			scx <= 8'h00;
			lyc <= 8'h00;
			dma_page <= 8'h00;
			bgp <= bgp_reset;
		end else if (reg_wr) begin
			case (wb_adr[7:0])
				reg_lcdc: lcdc <= wb_dat_w;
				// only the enable bits are writable
				reg_stat: stat_en <= wb_dat_w[6:3];
				reg_scy: scy <= wb_dat_w;
				reg_scx: scx <= wb_dat_w;
				reg_lyc: lyc <= wb_dat_w;
				reg_dma: dma_page <= wb_dat_w;
				reg_bgp: bgp <= wb_dat_w;
				// ly is read only, the rest unmapped
				default: ;
			endcase
		end
	end

	// read mux, unmapped offsets float high
	always_comb begin
		case (wb_adr[7:0])
			reg_lcdc: reg_rdata = lcdc;
			reg_stat: reg_rdata = {1'b1, stat_en, lyc_match, tm.mode};
			reg_scy: reg_rdata = scy;
			reg_scx: reg_rdata = scx;
			reg_ly: reg_rdata = tm.v_cnt;
			reg_lyc: reg_rdata = lyc;
			reg_dma: reg_rdata = dma_page;
			reg_bgp: reg_rdata = bgp;
			default: reg_rdata = 8'hff;
		endcase
	end

	// ------------------------------------------------------------------
	// control to timing and oam
	// ------------------------------------------------------------------

	assign tm.lcd_on = lcdc[7];
	assign tm.fine_scroll = (scx[2:0] != 3'd0);

	// oam strobe lines up with the edge that raises ack
	assign op.cpu_req = req && wb_adr[8];
	assign op.cpu_we = wb_we;
	assign op.cpu_index = wb_adr[7:0];
	assign op.cpu_wdata = wb_dat_w;
	// dma page register is updated on the same edge
	assign op.dma_start = reg_wr && (wb_adr[7:0] == reg_dma);
	assign op.dma_page = dma_page;

endmodule

//--- src/lcd_timing.sv
module lcd_timing (
	input  logic clk_reg,
	input  logic reset,
	lcd_timing_if.timing tm
);
	import lcd_pkg::*;

	h_cnt_t h_cnt;
	v_cnt_t v_cnt;
	// first hblank cycle of the current line
	h_cnt_t draw_end;
	logic line_end;
	logic frame_end;

	assign line_end = (h_cnt == h_cnt_t'(line_cycles - 1));
	assign frame_end = (v_cnt == v_cnt_t'(frame_lines - 1));

	// ------------------------------------------------------------------
	// horizontal and vertical counters
	// ------------------------------------------------------------------

	always_ff @(posedge clk_reg) begin
		if (reset) begin
			h_cnt <= '0;
			v_cnt <= '0;
			draw_end <= h_cnt_t'(oam_cycles + mode3_base);
		end else if (!tm.lcd_on) begin
			// display off, park at start of frame
			h_cnt <= '0;
			v_cnt <= '0;
		end else begin
			if (line_end) begin
				h_cnt <= '0;
				if (frame_end)
					v_cnt <= '0;
				else
					v_cnt <= v_cnt + 8'd1;
			end else begin
				h_cnt <= h_cnt + 9'd1;
			end

			// mode 3 length fixed two clocks before drawing starts
			if (h_cnt == h_cnt_t'(oam_cycles - 2)) begin
				if (tm.fine_scroll)
					draw_end <= h_cnt_t'(oam_cycles + mode3_base + mode3_extra);
				else
					draw_end <= h_cnt_t'(oam_cycles + mode3_base);
			end
		end
	end

	// ------------------------------------------------------------------
	// mode decode
	// ------------------------------------------------------------------

	always_comb begin
		if (!tm.lcd_on)
			tm.mode = mode_hblank;
		else if (v_cnt >= v_cnt_t'(visible_lines))
			tm.mode = mode_vblank;
		else if (h_cnt < h_cnt_t'(oam_cycles))
			tm.mode = mode_oam;
		else if (h_cnt < draw_end)
			tm.mode = mode_draw;
		else
			tm.mode = mode_hblank;
	end

	assign tm.h_cnt = h_cnt;
	assign tm.v_cnt = v_cnt;

endmodule

//--- src/lcd_top.sv
module lcd_top (
	input  logic clk_reg,
	input  logic reset,
	// wishbone classic slave
	input  logic wb_cyc,
	input  logic wb_stb,
	input  logic wb_we,
	input  logic [8:0] wb_adr,
	input  logic [7:0] wb_dat_w,
	output logic [7:0] wb_dat_r,
	output logic wb_ack,
	// display state
	output lcd_pkg::lcd_mode_t mode,
	output logic lcd_on,
	output logic irq,
	output logic vblank_irq,
	// oam dma source
	output logic dma_rd,
	output logic [15:0] dma_addr,
	input  logic [7:0] dma_data
);
	import lcd_pkg::*;

	logic [3:0] stat_en;
	v_cnt_t lyc;

	lcd_timing_if tm_if ();
	oam_port_if op_if ();

	lcd_timing timing_i (
		.clk_reg (clk_reg),
		.reset (reset),
		.tm (tm_if.timing)
	);

	lcd_regs regs_i (
		.clk_reg (clk_reg),
		.reset (reset),
		.wb_cyc (wb_cyc),
		.wb_stb (wb_stb),
		.wb_we (wb_we),
		.wb_adr (wb_adr),
		.wb_dat_w (wb_dat_w),
		.wb_dat_r (wb_dat_r),
		.wb_ack (wb_ack),
		.tm (tm_if.regs),
		.op (op_if.cpu),
		.stat_en (stat_en),
		.lyc (lyc)
	);

	oam_dma oam_i (
		.clk_reg (clk_reg),
		.reset (reset),
		.op (op_if.mem),
		.tm (tm_if.observer),
		.dma_rd (dma_rd),
		.dma_addr (dma_addr),
		.dma_data (dma_data)
	);

	stat_irq irq_i (
		.clk_reg (clk_reg),
		.reset (reset),
		.tm (tm_if.observer),
		.stat_en (stat_en),
		.lyc (lyc),
		.irq (irq),
		.vblank_irq (vblank_irq)
	);

	assign mode = tm_if.mode;
	assign lcd_on = tm_if.lcd_on;

endmodule

//--- src/oam_dma.sv
module oam_dma (
	input  logic clk_reg,
	input  logic reset,
	oam_port_if.mem op,
	lcd_timing_if.observer tm,
	output logic dma_rd,
	output logic [15:0] dma_addr,
	input  logic [7:0] dma_data
);
	import lcd_pkg::*;

	logic [7:0] oam_mem [oam_size];
	logic dma_active;
	// byte index in [9:2], phase within the byte in [1:0]
	logic [9:0] dma_cnt;
	logic dma_last;
	logic dma_wr;
	logic cpu_blocked;
	logic cpu_in_range;
	logic cpu_wr;

	// ------------------------------------------------------------------
	// dma engine
	// ------------------------------------------------------------------

	assign dma_last = (dma_cnt == 10'(oam_size * dma_step - 1));

	always_ff @(posedge clk_reg) begin
		if (reset) begin
			dma_active <= 1'b0;
			dma_cnt <= '0;
		end else if (op.dma_start) begin
			// a new write restarts the transfer from byte 0
			dma_active <= 1'b1;
			dma_cnt <= '0;
		end else if (dma_active) begin
			if (dma_last)
				dma_active <= 1'b0;
			else
				dma_cnt <= dma_cnt + 10'd1;
		end
	end

	assign dma_rd = dma_active;
	assign dma_addr = {op.dma_page, dma_cnt[9:2]};
	// source data has settled by phase 2
	assign dma_wr = dma_active && (dma_cnt[1:0] == 2'd2);

	// ------------------------------------------------------------------
	// cpu access and arbitration
	// ------------------------------------------------------------------

	// ppu owns oam in modes 2 and 3, dma owns it while running
	assign cpu_blocked = dma_active || (tm.mode == mode_oam) || (tm.mode == mode_draw);
	assign cpu_in_range = (op.cpu_index < 8'(oam_size));
	assign cpu_wr = op.cpu_req && op.cpu_we && cpu_in_range && !cpu_blocked;

	always_ff @(posedge clk_reg) begin
		if (dma_wr)
			oam_mem[dma_cnt[9:2]] <= dma_data;
		else if (cpu_wr)
			oam_mem[op.cpu_index] <= op.cpu_wdata;
	end

	// combinational so the register block can latch it with ack
	always_comb begin
		if (cpu_blocked || !cpu_in_range)
			op.cpu_rdata = 8'hff;
		else
			op.cpu_rdata = oam_mem[op.cpu_index];
	end

endmodule

//--- src/stat_irq.sv
module stat_irq (
	input  logic clk_reg,
	input  logic reset,
	lcd_timing_if.observer tm,
	input  logic [3:0] stat_en,
	input  lcd_pkg::v_cnt_t lyc,
	output logic irq,
	output logic vblank_irq
);
	import lcd_pkg::*;

	// mode was draw in the previous cycle
	logic was_draw;
	logic lyc_ev;
	logic oam_ev;
	logic vbl_ev;
	logic hbl_ev;
	logic stat_hit;

	assign lyc_ev = (tm.h_cnt == 9'd0) && (tm.v_cnt == lyc);
	assign oam_ev = (tm.h_cnt == 9'd0);
	// last cycle of line 143
	assign vbl_ev = (tm.h_cnt == h_cnt_t'(line_cycles - 1)) &&
		(tm.v_cnt == v_cnt_t'(visible_lines - 1));
	// first hblank cycle after mode 3
	assign hbl_ev = was_draw && (tm.mode == mode_hblank);

	// stat_en[3:0] holds stat bits 6:3
	assign stat_hit = (stat_en[3] && lyc_ev) || (stat_en[2] && oam_ev) ||
		(stat_en[1] && vbl_ev) || (stat_en[0] && hbl_ev);

	always_ff @(posedge clk_reg) begin
		if (reset) begin
			was_draw <= 1'b0;
			irq <= 1'b0;
			vblank_irq <= 1'b0;
		end else begin
			was_draw <= (tm.mode == mode_draw);
			// back to back events merge into one pulse, like a shared stat line
			irq <= tm.lcd_on && stat_hit && !irq;
			vblank_irq <= tm.lcd_on && vbl_ev;
		end
	end

endmodule
